// File: verilog/mul_pkg.sv
package mul_pkg;

	localparam int xlen = 64;
	localparam int opw = xlen + 2;       // Two guard bits carry the sign
	localparam int ppw = 2 * opw;        // Full width of every partial product
	localparam int pp_cnt = opw / 2;     // One Booth row per two multiplier bits
	localparam int grp_w = pp_cnt - 2;   // Carries handed from column to column

	typedef struct packed {
		logic            mulw;
		logic [1:0]      mul_signed;   // Bit 0 signs the multiplicand, nonzero signs the multiplier
		logic [xlen-1:0] multiplicand;
		logic [xlen-1:0] multiplier;
	} mul_req_t;

	typedef struct packed {
		logic [xlen-1:0] hi;
		logic [xlen-1:0] lo;
	} mul_result_t;

	// Carry-save form of the product, the last two Booth +1 terms ride along
	typedef struct packed {
		logic [ppw-1:0] sum;
		logic [ppw-2:0] carry;   // Bit j holds the carry of column j, weight j+1
		logic           neg_lo;
		logic           neg_hi;
	} csa_pair_t;

endpackage

// File: verilog/mul_operand_ext.sv
`timescale 1ns/1ns

module mul_operand_ext (
	input  mul_pkg::mul_req_t       req,
	input  logic                    mul_valid,
	output logic [mul_pkg::opw-1:0] mul_a,
	output logic [mul_pkg::opw-1:0] mul_b
);

	import mul_pkg::*;

	localparam int half = xlen / 2;

	logic [half-1:0] a_hi;
	logic [half-1:0] b_hi;
	logic            a_sign;
	logic            b_sign;

	assign a_hi = req.mulw ? {half{req.multiplicand[half-1]}} : req.multiplicand[xlen-1:half];
	assign b_hi = req.mulw ? {half{req.multiplier[half-1]}} : req.multiplier[xlen-1:half];

	assign a_sign = req.mul_signed[0] & a_hi[half-1];
	assign b_sign = (req.mul_signed != 2'b00) & b_hi[half-1];   // Codes 01, 10 and 11

	// Zero operands keep the whole tree still between requests
	assign mul_a = mul_valid ? {{2{a_sign}}, a_hi, req.multiplicand[half-1:0]} : '0;
	assign mul_b = mul_valid ? {{2{b_sign}}, b_hi, req.multiplier[half-1:0]} : '0;

endmodule

// File: verilog/booth_pp.sv
`timescale 1ns/1ns

module booth_pp (
	input  logic [2:0]              window,
	input  logic [mul_pkg::ppw-1:0] mcand,
	output logic [mul_pkg::ppw-1:0] pp,
	output logic                    neg
);

	logic                    sel_one;
	logic                    sel_two;
	logic [mul_pkg::ppw-1:0] pp_mag;

	// 001 and 010 give +1, 101 and 110 give -1
	assign sel_one = window[0] ^ window[1];
	assign sel_two = (window == 3'b011) || (window == 3'b100);

	// 111 is minus zero and must not add a stray one
	assign neg = window[2] & ~(window[1] & window[0]);

	always_comb begin
		if (sel_one) begin
			pp_mag = mcand;
		end else if (sel_two) begin
			pp_mag = mcand << 1;
		end else begin
			pp_mag = '0;
		end
	end

	// Ones complement here, the tree adds the +1 at bit 0
	assign pp = neg ? ~pp_mag : pp_mag;

endmodule

// File: verilog/booth_array.sv
`timescale 1ns/1ns

module booth_array (
	input  logic [mul_pkg::opw-1:0]                        mul_a,
	input  logic [mul_pkg::opw-1:0]                        mul_b,
	output logic [mul_pkg::ppw-1:0][mul_pkg::pp_cnt-1:0]   columns,
	output logic [mul_pkg::pp_cnt-1:0]                     neg
);

	import mul_pkg::*;

	logic [opw:0]                   a_win;
	logic [ppw-1:0]                 b_wide;
	logic [pp_cnt-1:0][ppw-1:0]     rows;

	assign a_win = {mul_a, 1'b0};   // Implicit zero below bit 0 for the first window
	assign b_wide = {{(ppw-opw){mul_b[opw-1]}}, mul_b};

	for (genvar k = 0; k < pp_cnt; k++) begin : g_row
		booth_pp i_booth_pp (
			.window(a_win[2*k +: 3]),
			.mcand (b_wide << (2*k)),
			.pp    (rows[k]),
			.neg   (neg[k])
		);
	end

	// Regroup so that each column holds bit j of every row
	always_comb begin
		for (int j = 0; j < ppw; j++) begin
			for (int k = 0; k < pp_cnt; k++) begin
				columns[j][k] = rows[k][j];
			end
		end
	end

endmodule

// File: verilog/wallace_column.sv
`timescale 1ns/1ns

module wallace_column (
	input  logic [mul_pkg::pp_cnt-1:0] din,
	input  logic [mul_pkg::grp_w-1:0]  cin,
	output logic [mul_pkg::grp_w-1:0]  cout,
	output logic                       carry,
	output logic                       sum
);

	// Returns {carry, sum} of three bits
	function automatic logic [1:0] fa(input logic [2:0] x);
		return {(x[0] & x[1]) | (x[2] & (x[0] ^ x[1])), ^x};
	endfunction

	logic [10:0] s1, c1;
	logic [21:0] l2_in;
	logic [6:0]  s2, c2;
	logic [14:0] l3_in;
	logic [4:0]  s3, c3;
	logic [9:0]  l4_in;
	logic [2:0]  s4, c4;
	logic [6:0]  l5_in;
	logic [1:0]  s5, c5;
	logic [4:0]  l6_in;
	logic        s6, c6;
	logic [3:0]  l7_in;
	logic        s7, c7;
	logic [2:0]  l8_in;
	logic        s8, c8;

	for (genvar i = 0; i < 11; i++) begin : g_l1
		assign {c1[i], s1[i]} = fa(din[3*i +: 3]);
	end

	// Each level picks up the carries the previous column made one level earlier
	assign l2_in = {cin[10:0], s1};
	for (genvar i = 0; i < 7; i++) begin : g_l2
		assign {c2[i], s2[i]} = fa(l2_in[3*i +: 3]);
	end

	assign l3_in = {cin[17:11], l2_in[21], s2};
	for (genvar i = 0; i < 5; i++) begin : g_l3
		assign {c3[i], s3[i]} = fa(l3_in[3*i +: 3]);
	end

	assign l4_in = {cin[22:18], s3};
	for (genvar i = 0; i < 3; i++) begin : g_l4
		assign {c4[i], s4[i]} = fa(l4_in[3*i +: 3]);
	end

	assign l5_in = {cin[25:23], l4_in[9], s4};
	for (genvar i = 0; i < 2; i++) begin : g_l5
		assign {c5[i], s5[i]} = fa(l5_in[3*i +: 3]);
	end

	assign l6_in = {cin[27:26], l5_in[6], s5};
	assign {c6, s6} = fa(l6_in[2:0]);

	assign l7_in = {cin[28], l6_in[4:3], s6};
	assign {c7, s7} = fa(l7_in[2:0]);

	assign l8_in = {cin[29], l7_in[3], s7};
	assign {c8, s8} = fa(l8_in);

	assign cout = {c8, c7, c6, c5, c4, c3, c2, c1};

	// The neighbour's last carry meets the final sum in a half adder
	assign sum = s8 ^ cin[30];
	assign carry = s8 & cin[30];

endmodule

// File: verilog/wallace_tree.sv
`timescale 1ns/1ns

module wallace_tree (
	input  logic [mul_pkg::ppw-1:0][mul_pkg::pp_cnt-1:0] columns,
	input  logic [mul_pkg::pp_cnt-1:0]                   neg,
	output mul_pkg::csa_pair_t                           csa
);

	import mul_pkg::*;

	logic [ppw-1:0][grp_w-1:0] grp;   // grp[j] feeds column j
	logic [ppw-1:0]            sum_v;
	logic [ppw-2:0]            carry_v;

	// All Booth +1 terms sit at weight 0, the first 31 enter column 0 directly
	assign grp[0] = neg[grp_w-1:0];

	for (genvar j = 0; j < ppw; j++) begin : g_col
		if (j < ppw - 1) begin : g_mid
			wallace_column i_wallace_column (
				.din  (columns[j]),
				.cin  (grp[j]),
				.cout (grp[j+1]),
				.carry(carry_v[j]),
				.sum  (sum_v[j])
			);
		end else begin : g_top
			wallace_column i_wallace_column (
				.din  (columns[j]),
				.cin  (grp[j]),
				.cout (),
				.carry(),
				.sum  (sum_v[j])
			);
		end
	end

	assign csa = '{sum: sum_v, carry: carry_v, neg_lo: neg[pp_cnt-2], neg_hi: neg[pp_cnt-1]};

endmodule

// File: verilog/booth_wallace_mul.sv
`timescale 1ns/1ns

module booth_wallace_mul (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 mul_valid,
	input  logic                 flush,
	input  mul_pkg::mul_req_t    req,
	output logic                 out_valid,
	output mul_pkg::mul_result_t result
);

	import mul_pkg::*;

	logic [opw-1:0]             mul_a;
	logic [opw-1:0]             mul_b;
	logic [ppw-1:0][pp_cnt-1:0] columns;
	logic [pp_cnt-1:0]          neg;
	csa_pair_t                  csa_d;
	csa_pair_t                  csa_q;
	logic                       s1_valid;
	logic [ppw-1:0]             product;

	mul_operand_ext i_mul_operand_ext (
		.req      (req),
		.mul_valid(mul_valid),
		.mul_a    (mul_a),
		.mul_b    (mul_b)
	);

	booth_array i_booth_array (
		.mul_a  (mul_a),
		.mul_b  (mul_b),
		.columns(columns),
		.neg    (neg)
	);

	wallace_tree i_wallace_tree (
		.columns(columns),
		.neg    (neg),
		.csa    (csa_d)
	);

	// Stage one holds the carry-save pair
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			csa_q <= '0;
		end else begin
			s1_valid <= mul_valid & ~flush;
			if (mul_valid) begin
				csa_q <= csa_d;
			end
		end
	end

	// Carry vector moves up one place, row 31 fills the hole at bit 0
	assign product = csa_q.sum + {csa_q.carry, csa_q.neg_lo} + {{(ppw-1){1'b0}}, csa_q.neg_hi};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			result <= '0;
		end else begin
			out_valid <= s1_valid & ~flush;
			if (s1_valid && !flush) begin
				result <= '{hi: product[2*xlen-1:xlen], lo: product[xlen-1:0]};
			end
		end
	end

endmodule

// File: tb/tb_booth_wallace_mul.sv
`timescale 1ns/1ns

module tb_booth_wallace_mul;

	import mul_pkg::*;

	localparam int n_corner = 4 * 25;
	localparam int n_word = 4 * 16;
	localparam int n_burst = 300;
	localparam int n_gap = 100;
	localparam int drain_max = 12;
	localparam int test_cycles = 8 + n_corner + n_word + n_burst + 12 + n_gap * 4
		+ 7 * (drain_max + 3);
	localparam int watchdog_ns = (test_cycles + 200) * 4;

	typedef struct packed {
		mul_result_t res;
		logic [31:0] due;   // Cycle count at which out_valid must show this result
	} exp_t;

	logic        clk;
	logic        rst_n;
	logic        mul_valid;
	logic        flush;
	mul_req_t    req;
	logic        out_valid;
	mul_result_t result;

	exp_t        exp_q[$];
	exp_t        cur;
	int          cyc;
	int          err_cnt;
	int          out_cnt;
	int          tests_pass;
	int          tests_fail;
	logic        prev_sent;
	logic [31:0] lcg_state;
	logic [63:0] corner[5];

	booth_wallace_mul i_booth_wallace_mul (
		.clk      (clk),
		.rst_n    (rst_n),
		.mul_valid(mul_valid),
		.flush    (flush),
		.req      (req),
		.out_valid(out_valid),
		.result   (result)
	);

	always #2 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi, lo};
	endfunction

	function automatic mul_req_t rand_req(input logic word);
		mul_req_t    r;
		logic [31:0] x;
		x = lcg_next();
		r.mulw = word;
		r.mul_signed = x[31:30];
		r.multiplicand = rand64();
		r.multiplier = rand64();
		return r;
	endfunction

	// Widen both operands to 130 bits as the code says, then keep the low 128 bits
	function automatic mul_result_t ref_mul(input mul_req_t r);
		logic [63:0]  a;
		logic [63:0]  b;
		logic [129:0] wa;
		logic [129:0] wb;
		logic [129:0] p;
		a = r.mulw ? {{32{r.multiplicand[31]}}, r.multiplicand[31:0]} : r.multiplicand;
		b = r.mulw ? {{32{r.multiplier[31]}}, r.multiplier[31:0]} : r.multiplier;
		wa = r.mul_signed[0] ? {{66{a[63]}}, a} : {66'd0, a};
		wb = (r.mul_signed != 2'b00) ? {{66{b[63]}}, b} : {66'd0, b};
		p = wa * wb;
		return '{hi: p[127:64], lo: p[63:0]};
	endfunction

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	// Drives one cycle of stimulus and keeps the expected queue in step with the pipeline
	task automatic step_drive(input logic valid, input mul_req_t r, input logic fl);
		exp_t e;
		@(posedge clk);
		#1;
		if (fl && prev_sent) begin
			e = exp_q.pop_back();   // The request now in stage one dies with the flush
		end
		mul_valid = valid;
		req = r;
		flush = fl;
		if (valid && !fl) begin
			e.res = ref_mul(r);
			e.due = cyc + 2;
			exp_q.push_back(e);
		end
		prev_sent = valid && !fl;
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < drain_max) begin
			step_drive(1'b0, '0, 1'b0);
			n++;
		end
		repeat (3) step_drive(1'b0, '0, 1'b0);   // Room for a stray out_valid to show up
		if (exp_q.size() != 0) begin
			$display("%0d expected results never came out of the multiplier", exp_q.size());
			err_cnt++;
			exp_q.delete();
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		if (err_cnt == err_before) begin
			tests_pass++;
			$display("test %s passed", name);
		end else begin
			tests_fail++;
			$display("test %s failed with %0d errors", name, err_cnt - err_before);
		end
	endtask

	always @(negedge clk) begin
		if (out_valid) begin
			out_cnt++;
			if (exp_q.size() == 0) begin
				$display("out_valid went high at %0t while no request was pending", $time);
				err_cnt++;
			end else begin
				cur = exp_q.pop_front();
				check_value("result hi", result.hi, cur.res.hi);
				check_value("result lo", result.lo, cur.res.lo);
				check_value("arrival cycle", 64'(cyc), 64'(cur.due));
			end
		end
	end

	initial begin
		#(watchdog_ns);
		$display("Watchdog expired before the tests finished");
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		int          e0;
		int          o0;
		mul_req_t    r;
		logic [31:0] w;
		clk = 1'b0;
		rst_n = 1'b0;
		mul_valid = 1'b0;
		flush = 1'b0;
		req = '0;
		err_cnt = 0;
		out_cnt = 0;
		tests_pass = 0;
		tests_fail = 0;
		prev_sent = 1'b0;
		lcg_state = 32'd79968;
		corner[0] = 64'd0;
		corner[1] = 64'd1;
		corner[2] = {64{1'b1}};
		corner[3] = {1'b1, 63'd0};
		corner[4] = {1'b0, {63{1'b1}}};
		repeat (8) @(posedge clk);
		#1 rst_n = 1'b1;

		e0 = err_cnt;
		check_value("out_valid after reset", 64'(out_valid), 64'd0);
		check_value("result hi after reset", result.hi, 64'd0);
		check_value("result lo after reset", result.lo, 64'd0);
		step_drive(1'b1, rand_req(1'b0), 1'b0);
		drain();
		end_test("reset", e0);

		e0 = err_cnt;
		for (int c = 0; c < 4; c++) begin
			for (int i = 0; i < 5; i++) begin
				for (int j = 0; j < 5; j++) begin
					r.mulw = 1'b0;
					r.mul_signed = 2'(c);
					r.multiplicand = corner[i];
					r.multiplier = corner[j];
					step_drive(1'b1, r, 1'b0);
				end
			end
		end
		drain();
		end_test("corners", e0);

		e0 = err_cnt;
		for (int c = 0; c < 4; c++) begin
			for (int i = 0; i < n_word / 4; i++) begin
				r = rand_req(1'b1);   // Upper operand bits stay random and must not matter
				r.mul_signed = 2'(c);
				step_drive(1'b1, r, 1'b0);
			end
		end
		drain();
		end_test("word mode", e0);

		e0 = err_cnt;
		o0 = out_cnt;
		for (int i = 0; i < n_burst; i++) begin
			w = lcg_next();
			step_drive(1'b1, rand_req(w[28]), 1'b0);
		end
		drain();
		check_value("burst result count", 64'(out_cnt - o0), 64'(n_burst));
		end_test("throughput", e0);

		// The oldest request is already in the result register when the flush lands
		e0 = err_cnt;
		o0 = out_cnt;
		step_drive(1'b1, rand_req(1'b0), 1'b0);
		step_drive(1'b1, rand_req(1'b0), 1'b0);
		step_drive(1'b1, rand_req(1'b0), 1'b1);
		step_drive(1'b1, rand_req(1'b0), 1'b1);
		drain();
		step_drive(1'b1, rand_req(1'b0), 1'b0);
		drain();
		check_value("flush result count", 64'(out_cnt - o0), 64'd2);
		end_test("flush", e0);

		e0 = err_cnt;
		o0 = out_cnt;
		for (int i = 0; i < n_gap; i++) begin
			w = lcg_next();
			repeat (w[31:30]) step_drive(1'b0, '0, 1'b0);
			w = lcg_next();
			step_drive(1'b1, rand_req(w[28]), 1'b0);
		end
		drain();
		check_value("gap result count", 64'(out_cnt - o0), 64'(n_gap));
		end_test("gaps", e0);

		$display("%0d tests passed, %0d tests failed, %0d errors", tests_pass, tests_fail,
			err_cnt);
		if (err_cnt == 0 && tests_fail == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: vlog.f
verilog/mul_pkg.sv
verilog/mul_operand_ext.sv
verilog/booth_pp.sv
verilog/booth_array.sv
verilog/wallace_column.sv
verilog/wallace_tree.sv
verilog/booth_wallace_mul.sv
tb/tb_booth_wallace_mul.sv

// File: run.sh
#!/bin/bash
# Compile with Verilator, run, and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f vlog.f --top-module tb_booth_wallace_mul -Mdir obj_dir \
	&& ./obj_dir/Vtb_booth_wallace_mul | tee sim.log \
	&& grep -qx "STATUS: PASS" sim.log \
	|| { echo "Simulation failed"; exit 1; }

echo "Simulation passed"
exit 0
